/* files.f */
+incdir+rtl
rtl/lstm_pkg.sv
rtl/lstm_axil_regs.sv
rtl/lstm_gate_engine.sv
rtl/lstm_state_update.sv
rtl/lstm_cell_top.sv
dv/lstm_asserts.sv
dv/lstm_tb.sv

/* dv/lstm_tb.sv */
`include "lstm_defs.svh"

module lstm_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 8;
	localparam int WAIT_LIMIT   = 32;
	// far longer than the whole sequence needs
	localparam int WATCHDOG_NS  = 20000;
	localparam logic [31:0] SEED = 32'h46f2_faa8;

	logic                    clk = 1'b0;
	logic                    i_rst_n;
	logic [`LSTM_AW-1:0]     i_awaddr;
	logic                    i_awvalid;
	logic                    o_awready;
	logic [`LSTM_BUS_DW-1:0] i_wdata;
	logic [3:0]              i_wstrb;
	logic                    i_wvalid;
	logic                    o_wready;
	logic [1:0]              o_bresp;
	logic                    o_bvalid;
	logic                    i_bready;
	logic [`LSTM_AW-1:0]     i_araddr;
	logic                    i_arvalid;
	logic                    o_arready;
	logic [`LSTM_BUS_DW-1:0] o_rdata;
	logic [1:0]              o_rresp;
	logic                    o_rvalid;
	logic                    i_rready;
	logic                    o_irq;

	// model copy of the weights, gate order i, a, f, o
	int          wx0 [4];
	int          wx1 [4];
	int          wh [4];
	int          bias [4];
	int          c_m;
	int          h_m;
	logic [31:0] x_last;
	int          checks;
	int          value_errors;
	int          resp_errors;
	int          other_errors;

	lstm_cell_top dut (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
		.i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wvalid(i_wvalid), .o_wready(o_wready),
		.o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
		.i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
		.o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
		.o_irq(o_irq)
	);

	bind lstm_cell_top lstm_asserts u_asserts (
		.clk(clk), .i_rst_n(i_rst_n), .i_awaddr(i_awaddr), .i_awvalid(i_awvalid),
		.o_awready(o_awready), .i_wdata(i_wdata), .i_wvalid(i_wvalid),
		.o_wready(o_wready), .o_bresp(o_bresp), .o_bvalid(o_bvalid),
		.i_bready(i_bready), .i_araddr(i_araddr), .i_arvalid(i_arvalid),
		.o_arready(o_arready), .o_rdata(o_rdata), .o_rvalid(o_rvalid),
		.i_rready(i_rready), .o_irq(o_irq), .i_busy(u_regs.busy_q)
	);

	always #(HALF_PERIOD) clk = ~clk;

	function automatic int saturate16(input longint v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return int'(v);
	endfunction

	// x/4 + 0.5 in Q8.8, clamped to 0..1.0
	function automatic int sigmoid_hard(input int x);
		int t;
		t = (x >>> 2) + 128;
		if (t < 0)
			return 0;
		if (t > 256)
			return 256;
		return t;
	endfunction

	function automatic int tanh_hard(input int x);
		if (x > 256)
			return 256;
		if (x < -256)
			return -256;
		return x;
	endfunction

	// weighted sum of one gate row before activation
	function automatic int gate_pre(input int g, input int x0, input int x1);
		longint acc;
		acc = longint'(bias[g]) * 256 + longint'(wx0[g]) * x0 + longint'(wx1[g]) * x1
			+ longint'(wh[g]) * h_m;
		return saturate16(acc >>> 8);
	endfunction

	// one timestep, carries c_m and h_m forward
	function automatic void model_step(input int x0, input int x1);
		int gi;
		int ga;
		int gf;
		int go_v;
		gi   = sigmoid_hard(gate_pre(0, x0, x1));
		ga   = tanh_hard(gate_pre(1, x0, x1));
		gf   = sigmoid_hard(gate_pre(2, x0, x1));
		go_v = sigmoid_hard(gate_pre(3, x0, x1));
		c_m  = saturate16(((longint'(gf) * c_m) >>> 8) + ((longint'(gi) * ga) >>> 8));
		h_m  = saturate16((longint'(go_v) * tanh_hard(c_m)) >>> 8);
	endfunction

	function automatic logic [31:0] weight_word(input logic [`LSTM_AW-1:0] addr);
		int g;
		g = (addr - `LSTM_REG_W_BASE) >> 3;
		if (addr[2])
			return {bias[g][15:0], wh[g][15:0]};
		return {wx1[g][15:0], wx0[g][15:0]};
	endfunction

	function automatic string reg_name(input logic [`LSTM_AW-1:0] a);
		case (a)
			`LSTM_REG_CTRL:   return "CTRL";
			`LSTM_REG_STATUS: return "STATUS";
			`LSTM_REG_X:      return "X";
			`LSTM_REG_HC:     return "HC";
			default:          return $sformatf("W@0x%02h", a);
		endcase
	endfunction

	// uniform in -limit..limit
	function automatic int rand_q(input int limit);
		return int'($urandom_range(2 * limit)) - limit;
	endfunction

	function automatic void set_gate(input int g, input int a0, input int a1,
		input int ah, input int b);
		wx0[g]  = a0;
		wx1[g]  = a1;
		wh[g]   = ah;
		bias[g] = b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %0t ns %s expected 0x%08h got 0x%08h", $time, name, exp, got);
			value_errors++;
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] got,
		input logic [1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("%s returned response code %0d instead of %0d", what, got, exp);
			resp_errors++;
		end
	endtask

	// hold delays bready, the request stays up through the stall
	task automatic axi_write(input logic [`LSTM_AW-1:0] addr, input logic [31:0] data,
		input int hold, output logic [1:0] resp);
		int n;
		@(negedge clk);
		i_awaddr  = addr;
		i_wdata   = data;
		i_awvalid = 1'b1;
		i_wvalid  = 1'b1;
		i_bready  = (hold == 0);
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!o_bvalid && n < WAIT_LIMIT);
		resp = o_bresp;
		// a pending response must keep the held request from being taken again
		if (!o_bvalid)
		begin
			$display("write to 0x%02h was never answered", addr);
			other_errors++;
		end
		else
			repeat (hold) @(negedge clk);
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
		i_bready  = 1'b1;
		while (o_bvalid) @(negedge clk);
		i_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`LSTM_AW-1:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
		int n;
		@(negedge clk);
		i_araddr  = addr;
		i_arvalid = 1'b1;
		i_rready  = (hold == 0);
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!o_rvalid && n < WAIT_LIMIT);
		data = o_rdata;
		resp = o_rresp;
		// arvalid stays up while rvalid is held
		if (!o_rvalid)
		begin
			$display("read of 0x%02h was never answered", addr);
			other_errors++;
		end
		else
			repeat (hold) @(negedge clk);
		i_arvalid = 1'b0;
		i_rready  = 1'b1;
		while (o_rvalid) @(negedge clk);
		i_rready = 1'b0;
	endtask

	task automatic write_ok(input logic [`LSTM_AW-1:0] addr, input logic [31:0] data,
		input int hold);
		logic [1:0] resp;
		axi_write(addr, data, hold, resp);
		check_resp({"write to ", reg_name(addr)}, resp, `LSTM_RESP_OKAY);
	endtask

	task automatic read_check(input logic [`LSTM_AW-1:0] addr, input logic [31:0] exp,
		input int hold);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, hold, data, resp);
		check_resp({"read of ", reg_name(addr)}, resp, `LSTM_RESP_OKAY);
		check_value(reg_name(addr), data, exp);
	endtask

	task automatic echo_check(input logic [`LSTM_AW-1:0] addr);
		logic [31:0] pattern;
		pattern = $urandom();
		write_ok(addr, pattern, 0);
		read_check(addr, pattern, 1);
	endtask

	task automatic load_weights();
		for (int a = `LSTM_REG_W_BASE; a <= `LSTM_REG_W_LAST; a += 4)
			write_ok(6'(a), weight_word(6'(a)), 0);
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!o_irq && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!o_irq)
		begin
			$display("no interrupt within %0d cycles of the start", WAIT_LIMIT);
			other_errors++;
		end
	endtask

	// write X, start, compare HC, then clear done through STATUS
	task automatic run_step(input int x0, input int x1, input bit double_start);
		x_last = {x1[15:0], x0[15:0]};
		write_ok(`LSTM_REG_X, x_last, 0);
		write_ok(`LSTM_REG_CTRL, 32'h1, 0);
		// lands while busy, must not queue
		if (double_start)
			write_ok(`LSTM_REG_CTRL, 32'h1, 0);
		model_step(x0, x1);
		wait_irq();
		read_check(`LSTM_REG_HC, {c_m[15:0], h_m[15:0]}, 0);
		read_check(`LSTM_REG_STATUS, 32'h1, 1);
		check_value("o_irq", o_irq, 0);
	endtask

	initial
	begin
		logic [31:0] data;
		logic [1:0]  resp;
		int          total;
		i_rst_n   = 1'b0;
		i_awaddr  = '0;
		i_awvalid = 1'b0;
		i_wdata   = '0;
		i_wstrb   = 4'hf;
		i_wvalid  = 1'b0;
		i_bready  = 1'b0;
		i_araddr  = '0;
		i_arvalid = 1'b0;
		i_rready  = 1'b0;
		checks = 0;
		value_errors = 0;
		resp_errors = 0;
		other_errors = 0;
		c_m = 0;
		h_m = 0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(negedge clk);
		i_rst_n = 1'b1;

		// reset values
		check_value("o_irq", o_irq, 0);
		read_check(`LSTM_REG_CTRL, 32'h0, 0);
		read_check(`LSTM_REG_STATUS, 32'h0, 0);
		read_check(`LSTM_REG_X, 32'h0, 0);
		read_check(`LSTM_REG_HC, 32'h0, 2);
		for (int a = `LSTM_REG_W_BASE; a <= `LSTM_REG_W_LAST; a += 4)
			read_check(6'(a), 32'h0, 0);

		// write and read back every data address
		echo_check(`LSTM_REG_X);
		for (int a = `LSTM_REG_W_BASE; a <= `LSTM_REG_W_LAST; a += 4)
			echo_check(6'(a));

		// hand-chosen weights, one step from zero state
		set_gate(0, 256, -128, 64, 32);
		set_gate(1, 384, 256, -256, 0);
		set_gate(2, -64, 128, 128, 256);
		set_gate(3, 192, -320, 0, 128);
		load_weights();
		run_step(384, -256, 1'b0);

		// random weights within +-2.0, chained steps
		for (int g = 0; g < 4; g++)
			set_gate(g, rand_q(512), rand_q(512), rand_q(512), rand_q(512));
		load_weights();
		repeat (5) run_step(rand_q(1024), rand_q(1024), 1'b0);
		write_ok(`LSTM_REG_CTRL, 32'h2, 0);
		c_m = 0;
		h_m = 0;
		read_check(`LSTM_REG_HC, 32'h0, 0);
		run_step(rand_q(1024), rand_q(1024), 1'b0);

		// illegal accesses leave everything untouched
		axi_write(`LSTM_REG_STATUS, 32'hffff_ffff, 2, resp);
		check_resp("write to STATUS", resp, `LSTM_RESP_SLVERR);
		axi_write(`LSTM_REG_HC, 32'h1234_5678, 0, resp);
		check_resp("write to HC", resp, `LSTM_RESP_SLVERR);
		axi_write(6'h30, 32'h0000_0101, 1, resp);
		check_resp("write to 0x30", resp, `LSTM_RESP_SLVERR);
		axi_read(6'h30, 2, data, resp);
		check_resp("read of 0x30", resp, `LSTM_RESP_SLVERR);
		check_value("rdata@0x30", data, 32'h0);
		read_check(`LSTM_REG_X, x_last, 0);
		read_check(`LSTM_REG_HC, {c_m[15:0], h_m[15:0]}, 0);
		read_check(`LSTM_REG_STATUS, 32'h0, 0);
		for (int a = `LSTM_REG_W_BASE; a <= `LSTM_REG_W_LAST; a += 4)
			read_check(6'(a), weight_word(6'(a)), 0);

		// start while busy, one result only
		run_step(rand_q(1024), rand_q(1024), 1'b1);
		repeat (3 * `LSTM_LATENCY) @(negedge clk);
		check_value("o_irq", o_irq, 0);
		read_check(`LSTM_REG_STATUS, 32'h0, 0);
		read_check(`LSTM_REG_HC, {c_m[15:0], h_m[15:0]}, 0);

		repeat (4) @(negedge clk);
		total = value_errors + resp_errors + other_errors + dut.u_asserts.fail_count;
		$display("checks %0d, value errors %0d, response errors %0d, other errors %0d, %s %0d",
			checks, value_errors, resp_errors, other_errors, "assertion failures",
			dut.u_asserts.fail_count);
		if (total == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

/* dv/lstm_asserts.sv */
`include "lstm_defs.svh"

module lstm_asserts
(
	input logic                    clk,
	input logic                    i_rst_n,
	input logic [`LSTM_AW-1:0]     i_awaddr,
	input logic                    i_awvalid,
	input logic                    o_awready,
	input logic [`LSTM_BUS_DW-1:0] i_wdata,
	input logic                    i_wvalid,
	input logic                    o_wready,
	input logic [1:0]              o_bresp,
	input logic                    o_bvalid,
	input logic                    i_bready,
	input logic [`LSTM_AW-1:0]     i_araddr,
	input logic                    i_arvalid,
	input logic                    o_arready,
	input logic [`LSTM_BUS_DW-1:0] o_rdata,
	input logic                    o_rvalid,
	input logic                    i_rready,
	input logic                    o_irq,
	input logic                    i_busy
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned       fail_count = 0;
	logic              start_acc;
	logic              rd_hc;
	logic signed [15:0] h_half;

	// start write accepted while idle
	assign start_acc = i_awvalid && i_wvalid && !o_bvalid && i_wdata[0]
		&& (i_awaddr == `LSTM_REG_CTRL) && !i_busy;
	assign h_half = o_rdata[15:0];

	// remembers whether the pending read response came from HC
	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			rd_hc <= 1'b0;
		else if (i_arvalid && o_arready)
			rd_hc <= (i_araddr == `LSTM_REG_HC);
	end

	a_b_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
		else
		begin
			$error("write response dropped or changed before bready");
			fail_count++;
		end

	a_r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata))
		else
		begin
			$error("read response dropped or changed before rready");
			fail_count++;
		end

	// low from the second reset edge through the first edge after release
	a_rst_quiet: assert property (@(posedge clk)
		!i_rst_n |=> !o_bvalid && !o_rvalid)
		else
		begin
			$error("bus response valid around reset");
			fail_count++;
		end

	// address and data taken together in one cycle
	a_wr_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_awvalid && i_wvalid && !o_bvalid |-> o_awready && o_wready)
		else
		begin
			$error("awready and wready not raised together for a write");
			fail_count++;
		end

	// a held response blocks new accepts on its own channel
	a_ready_low: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_bvalid && (o_awready || o_wready)) && !(o_rvalid && o_arready))
		else
		begin
			$error("ready raised while a response was still pending");
			fail_count++;
		end

	// irq flops on edge E+7, so its sample is first high one edge later
	a_irq_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
		start_acc |-> ##(`LSTM_LATENCY) !o_irq ##1 o_irq)
		else
		begin
			$error("interrupt not raised at the expected edge after start");
			fail_count++;
		end

	a_h_range: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_rvalid && rd_hc |-> (h_half >= -256) && (h_half <= 256))
		else
		begin
			$error("h half of HC outside -1.0..1.0");
			fail_count++;
		end

endmodule

/* rtl/lstm_cell_top.sv */
`include "lstm_defs.svh"

module lstm_cell_top
	import lstm_pkg::*;
(
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  logic [`LSTM_AW-1:0]     i_awaddr,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [`LSTM_BUS_DW-1:0] i_wdata,
	// byte strobes not supported, full-word writes only
	input  logic [3:0]              i_wstrb,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	output logic [1:0]              o_bresp,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	input  logic [`LSTM_AW-1:0]     i_araddr,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	output logic [`LSTM_BUS_DW-1:0] o_rdata,
	output logic [1:0]              o_rresp,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic                    o_irq
);

	logic start;
	logic clear;
	logic done;
	logic in_valid;
	logic out_valid;
	q_t   x0;
	q_t   x1;
	q_t   c;
	q_t   h;
	q_t   g_i;
	q_t   g_a;
	q_t   g_f;
	q_t   g_o;
	// gate rows indexed i, a, f, o
	q_t   w_x0 [4];
	q_t   w_x1 [4];
	q_t   w_h [4];
	q_t   b [4];

	lstm_axil_regs u_regs (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_awaddr  (i_awaddr),
		.i_awvalid (i_awvalid),
		.o_awready (o_awready),
		.i_wdata   (i_wdata),
		.i_wvalid  (i_wvalid),
		.o_wready  (o_wready),
		.o_bresp   (o_bresp),
		.o_bvalid  (o_bvalid),
		.i_bready  (i_bready),
		.i_araddr  (i_araddr),
		.i_arvalid (i_arvalid),
		.o_arready (o_arready),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.o_rvalid  (o_rvalid),
		.i_rready  (i_rready),
		.o_start   (start),
		.o_clear   (clear),
		.o_x0      (x0),
		.o_x1      (x1),
		.o_w_x0    (w_x0),
		.o_w_x1    (w_x1),
		.o_w_h     (w_h),
		.o_b       (b),
		.i_c       (c),
		.i_h       (h),
		.i_done    (done),
		.o_irq     (o_irq)
	);

	// input gate and tanh candidate
	lstm_gate_engine #(
		.SECOND_TANH (1'b1)
	) u_in_gates (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_start  (start),
		.i_x0     (x0),
		.i_x1     (x1),
		.i_h_prev (h),
		.i_w_x0   (w_x0[0:1]),
		.i_w_x1   (w_x1[0:1]),
		.i_w_h    (w_h[0:1]),
		.i_b      (b[0:1]),
		.o_g0     (g_i),
		.o_g1     (g_a),
		.o_valid  (in_valid)
	);

	// forget and output gates
	lstm_gate_engine #(
		.SECOND_TANH (1'b0)
	) u_out_gates (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_start  (start),
		.i_x0     (x0),
		.i_x1     (x1),
		.i_h_prev (h),
		.i_w_x0   (w_x0[2:3]),
		.i_w_x1   (w_x1[2:3]),
		.i_w_h    (w_h[2:3]),
		.i_b      (b[2:3]),
		.o_g0     (g_f),
		.o_g1     (g_o),
		.o_valid  (out_valid)
	);

	lstm_state_update u_state (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_clear     (clear),
		.i_gi        (g_i),
		.i_ga        (g_a),
		.i_gf        (g_f),
		.i_go        (g_o),
		.i_valid_in  (in_valid),
		.i_valid_out (out_valid),
		.o_c         (c),
		.o_h         (h),
		.o_done      (done)
	);

endmodule

/* rtl/lstm_state_update.sv */
`include "lstm_defs.svh"

module lstm_state_update
	import lstm_pkg::*;
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_clear,
	input  q_t   i_gi,
	input  q_t   i_ga,
	input  q_t   i_gf,
	input  q_t   i_go,
	input  logic i_valid_in,
	input  logic i_valid_out,
	output q_t   o_c,
	output q_t   o_h,
	output logic o_done
);

	localparam int PW = 2 * `LSTM_DW;

	q_t                   c_q;
	q_t                   h_q;
	q_t                   go_q;
	logic                 both_valid;
	logic                 c_upd;
	logic signed [PW-1:0] fc;
	logic signed [PW-1:0] ia;
	logic signed [PW-1:0] c_sum;
	logic signed [PW-1:0] oh;
	q_t                   c_next;
	q_t                   h_next;

	always_comb
	begin
		both_valid = i_valid_in && i_valid_out;
		// forget old state, add gated candidate
		fc     = i_gf * c_q;
		ia     = i_gi * i_ga;
		c_sum  = (fc >>> `LSTM_FRAC) + (ia >>> `LSTM_FRAC);
		c_next = sat_q(c_sum);
		// output uses the state registered one cycle earlier
		oh     = go_q * hard_tanh(c_q);
		h_next = sat_q(oh >>> `LSTM_FRAC);
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			c_q    <= '0;
			h_q    <= '0;
			c_upd  <= 1'b0;
			o_done <= 1'b0;
		end
		else
		begin
			c_upd  <= both_valid;
			o_done <= c_upd;
			if (i_clear)
			begin
				c_q <= '0;
				h_q <= '0;
			end
			else
			begin
				if (both_valid)
					c_q <= c_next;
				if (c_upd)
					h_q <= h_next;
			end
		end
	end

	// o gate held for the h stage
	always_ff @(posedge clk)
	begin
		if (both_valid)
			go_q <= i_go;
	end

	assign o_c = c_q;
	// engines latch h_prev during the clear pulse, so it reads as zero already
	assign o_h = i_clear ? '0 : h_q;

endmodule

/* rtl/lstm_gate_engine.sv */
`include "lstm_defs.svh"

module lstm_gate_engine
	import lstm_pkg::*;
#(
	parameter bit SECOND_TANH = 1'b0
)
(
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  q_t   i_x0,
	input  q_t   i_x1,
	input  q_t   i_h_prev,
	input  q_t   i_w_x0 [2],
	input  q_t   i_w_x1 [2],
	input  q_t   i_w_h [2],
	input  q_t   i_b [2],
	output q_t   o_g0,
	output q_t   o_g1,
	output logic o_valid
);

	localparam int ACC_W = 2 * `LSTM_DW;

	logic                    run;
	logic [1:0]              phase;
	logic                    last;
	q_t                      x0_q;
	q_t                      x1_q;
	q_t                      h_q;
	q_t                      w_x0_q [2];
	q_t                      w_x1_q [2];
	q_t                      w_h_q [2];
	logic signed [ACC_W-1:0] acc [2];
	q_t                      op_x;
	q_t                      op_w [2];
	logic signed [ACC_W-1:0] sum [2];
	q_t                      pre [2];
	q_t                      act [2];

	// phase 0 adds x0, phase 1 adds x1, phase 2 adds h and retires
	assign last = (phase == 2'd2);

	always_comb
	begin
		case (phase)
			2'd0:
			begin
				op_x = x0_q;
				op_w = w_x0_q;
			end
			2'd1:
			begin
				op_x = x1_q;
				op_w = w_x1_q;
			end
			default:
			begin
				op_x = h_q;
				op_w = w_h_q;
			end
		endcase
		for (int g = 0; g < 2; g++)
		begin
			// full precision product, scaled once at the end
			sum[g] = acc[g] + op_w[g] * op_x;
			pre[g] = sat_q(sum[g] >>> `LSTM_FRAC);
		end
		act[0] = hard_sigmoid(pre[0]);
		// second gate is the candidate in the input engine
		act[1] = SECOND_TANH ? hard_tanh(pre[1]) : hard_sigmoid(pre[1]);
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			run     <= 1'b0;
			phase   <= 2'd0;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= run && last;
			if (i_start)
			begin
				run   <= 1'b1;
				phase <= 2'd0;
			end
			else if (run)
			begin
				phase <= last ? 2'd0 : phase + 2'd1;
				run   <= !last;
			end
		end
	end

	// operands frozen for the whole pass
	always_ff @(posedge clk)
	begin
		if (i_start)
		begin
			x0_q   <= i_x0;
			x1_q   <= i_x1;
			h_q    <= i_h_prev;
			w_x0_q <= i_w_x0;
			w_x1_q <= i_w_x1;
			w_h_q  <= i_w_h;
			// bias preloaded at product scale
			for (int g = 0; g < 2; g++)
				acc[g] <= ACC_W'(i_b[g]) <<< `LSTM_FRAC;
		end
		else if (run)
		begin
			for (int g = 0; g < 2; g++)
				acc[g] <= sum[g];
		end
		if (run && last)
		begin
			o_g0 <= act[0];
			o_g1 <= act[1];
		end
	end

endmodule

/* rtl/lstm_axil_regs.sv */
`include "lstm_defs.svh"

module lstm_axil_regs
	import lstm_pkg::*;
(
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  logic [`LSTM_AW-1:0]     i_awaddr,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [`LSTM_BUS_DW-1:0] i_wdata,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	output logic [1:0]              o_bresp,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	input  logic [`LSTM_AW-1:0]     i_araddr,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	output logic [`LSTM_BUS_DW-1:0] o_rdata,
	output logic [1:0]              o_rresp,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	output logic                    o_start,
	output logic                    o_clear,
	output q_t                      o_x0,
	output q_t                      o_x1,
	output q_t                      o_w_x0 [4],
	output q_t                      o_w_x1 [4],
	output q_t                      o_w_h [4],
	output q_t                      o_b [4],
	input  q_t                      i_c,
	input  q_t                      i_h,
	input  logic                    i_done,
	output logic                    o_irq
);

	lstm_word_u                wword;
	logic                      wr_acc;
	logic                      rd_acc;
	logic                      wr_ctrl;
	logic                      wr_x;
	logic                      wr_w;
	logic                      wr_bad;
	logic [1:0]                wr_gate;
	logic [1:0]                rd_gate;
	logic                      rd_bad;
	logic [`LSTM_BUS_DW-1:0]   rd_word;
	logic                      busy_q;
	logic                      done_q;
	logic                      go;
	lstm_pair_s                hc_q;

	// weight words live at 0x10..0x2C, word aligned
	function automatic logic in_wmap(input logic [`LSTM_AW-1:0] a);
		return (a >= `LSTM_REG_W_BASE) && (a <= `LSTM_REG_W_LAST) && (a[1:0] == 2'b00);
	endfunction

	// both channels must be present, one response outstanding at most
	assign o_awready = i_awvalid && i_wvalid && !o_bvalid;
	assign o_wready  = o_awready;
	assign wr_acc    = o_awready;
	assign o_arready = !o_rvalid;
	assign rd_acc    = i_arvalid && o_arready;
	assign o_irq     = done_q;

	assign wword = i_wdata;

	// addr[5:3] minus 2 reduces to bits 5 and 3 over this range
	assign wr_gate = {i_awaddr[5], i_awaddr[3]};
	assign rd_gate = {i_araddr[5], i_araddr[3]};

	always_comb
	begin
		wr_ctrl = (i_awaddr == `LSTM_REG_CTRL);
		wr_x    = (i_awaddr == `LSTM_REG_X);
		wr_w    = in_wmap(i_awaddr);
		wr_bad  = !(wr_ctrl || wr_x || wr_w);
		// start only counts when idle
		go      = wr_acc && wr_ctrl && !busy_q && wword.ctrl.start;
	end

	// read mux
	always_comb
	begin
		rd_word = '0;
		rd_bad  = 1'b0;
		if (in_wmap(i_araddr))
		begin
			if (i_araddr[2])
				rd_word = {o_b[rd_gate], o_w_h[rd_gate]};
			else
				rd_word = {o_w_x1[rd_gate], o_w_x0[rd_gate]};
		end
		else
		begin
			case (i_araddr)
				`LSTM_REG_CTRL:   rd_word = '0;
				`LSTM_REG_STATUS: rd_word = {30'd0, busy_q, done_q};
				`LSTM_REG_X:      rd_word = {o_x1, o_x0};
				`LSTM_REG_HC:     rd_word = hc_q;
				default:          rd_bad  = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_bvalid <= 1'b0;
			o_bresp  <= `LSTM_RESP_OKAY;
			o_start  <= 1'b0;
			o_clear  <= 1'b0;
			o_x0     <= '0;
			o_x1     <= '0;
			for (int g = 0; g < 4; g++)
			begin
				o_w_x0[g] <= '0;
				o_w_x1[g] <= '0;
				o_w_h[g]  <= '0;
				o_b[g]    <= '0;
			end
		end
		else
		begin
			o_start <= go;
			// clear and start both pulse next cycle, clear wins downstream
			o_clear <= wr_acc && wr_ctrl && !busy_q && wword.ctrl.clear_state;
			if (wr_acc)
			begin
				o_bvalid <= 1'b1;
				o_bresp  <= wr_bad ? `LSTM_RESP_SLVERR : `LSTM_RESP_OKAY;
				if (wr_x)
				begin
					o_x1 <= wword.pair.hi;
					o_x0 <= wword.pair.lo;
				end
				if (wr_w && !i_awaddr[2])
				begin
					o_w_x1[wr_gate] <= wword.pair.hi;
					o_w_x0[wr_gate] <= wword.pair.lo;
				end
				if (wr_w && i_awaddr[2])
				begin
					o_b[wr_gate]   <= wword.pair.hi;
					o_w_h[wr_gate] <= wword.pair.lo;
				end
			end
			else if (i_bready)
				o_bvalid <= 1'b0;
		end
	end

	// status, result shadow and read channel
	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			busy_q   <= 1'b0;
			done_q   <= 1'b0;
			hc_q     <= '0;
			o_rvalid <= 1'b0;
			o_rresp  <= `LSTM_RESP_OKAY;
			o_rdata  <= '0;
		end
		else
		begin
			if (go)
				busy_q <= 1'b1;
			else if (i_done)
				busy_q <= 1'b0;
			// a new result beats the clear-on-read
			if (i_done)
				done_q <= 1'b1;
			else if (rd_acc && i_araddr == `LSTM_REG_STATUS)
				done_q <= 1'b0;
			if (o_clear)
				hc_q <= '0;
			else if (i_done)
				hc_q <= {i_c, i_h};
			if (rd_acc)
			begin
				o_rvalid <= 1'b1;
				o_rresp  <= rd_bad ? `LSTM_RESP_SLVERR : `LSTM_RESP_OKAY;
				o_rdata  <= rd_word;
			end
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

endmodule

/* rtl/lstm_pkg.sv */
`include "lstm_defs.svh"

package lstm_pkg;

	typedef logic signed [`LSTM_DW-1:0] q_t;

	// data view of a bus word
	typedef struct packed {
		q_t hi;
		q_t lo;
	} lstm_pair_s;

	// CTRL view of a bus word
	typedef struct packed {
		logic [`LSTM_BUS_DW-3:0] rsvd;
		logic                    clear_state;
		logic                    start;
	} lstm_ctrl_s;

	typedef union packed {
		lstm_pair_s pair;
		lstm_ctrl_s ctrl;
	} lstm_word_u;

	localparam int Q_MAX = (1 << (`LSTM_DW - 1)) - 1;
	localparam int Q_MIN = -(1 << (`LSTM_DW - 1));

	// clamp a wide sum into the 16 bit range
	function automatic q_t sat_q(input logic signed [2*`LSTM_DW-1:0] v);
		if (v > Q_MAX)
			return q_t'(Q_MAX);
		if (v < Q_MIN)
			return q_t'(Q_MIN);
		return v[`LSTM_DW-1:0];
	endfunction

	// x/4 + 0.5, held in 0..1
	function automatic q_t hard_sigmoid(input q_t x);
		int t;
		t = (x >>> 2) + (`LSTM_ONE / 2);
		if (t < 0)
			t = 0;
		else if (t > `LSTM_ONE)
			t = `LSTM_ONE;
		return q_t'(t);
	endfunction

	// identity inside -1..1
	function automatic q_t hard_tanh(input q_t x);
		if (x > `LSTM_ONE)
			return q_t'(`LSTM_ONE);
		if (x < -`LSTM_ONE)
			return q_t'(-`LSTM_ONE);
		return x;
	endfunction

endpackage

/* rtl/lstm_defs.svh */
`ifndef LSTM_DEFS_SVH
`define LSTM_DEFS_SVH

// signed Q8.8 fixed point
`define LSTM_DW          16
`define LSTM_FRAC        8
`define LSTM_ONE         256

// axi4-lite slave
`define LSTM_AW          6
`define LSTM_BUS_DW      32
`define LSTM_RESP_OKAY   2'b00
`define LSTM_RESP_SLVERR 2'b10

// register map, byte addresses
`define LSTM_REG_CTRL    6'h00
`define LSTM_REG_STATUS  6'h04
`define LSTM_REG_X       6'h08
`define LSTM_REG_HC      6'h0C
// two words per gate, gate order i, a, f, o
`define LSTM_REG_W_BASE  6'h10
`define LSTM_REG_W_LAST  6'h2C

// edges from accepted start write to visible result
`define LSTM_LATENCY     7

`endif
